// File: design/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  instr_t   instr,
   input  logic     z,
   output ctrl_t    ctrl,
   output mem_req_t req,
   output logic     load_ir,
   output logic     pc_incr,
   output logic     pc_branch,
   output logic     over
);

   typedef enum logic [3:0] {
      s_fetch, s_load_ir, s_decode, s_read_a, s_read_b, s_alu, s_write,
      s_addr, s_mem_wait, s_store_data, s_store, s_branch, s_halt
   } state_e;

   state_e state;
   state_e state_next;
   alu_op_e alu_op;
   logic taken;

   assign alu_op = alu_op_e'(instr.op);

   always_comb begin
      case (instr.cond)
         cond_always: taken = 1'b1;
         if_zero:     taken = z;
         if_not_zero: taken = !z;
         default:     taken = 1'b0;
      endcase
   end

   always_comb begin
      state_next = state;
      case (state)
         s_fetch:   state_next = s_load_ir;
         s_load_ir: state_next = s_decode;
         s_decode: begin
            // anything not matched below is skipped
            state_next = s_fetch;
            case (instr.opcode)
               op_move: begin
                  if (instr.op == mov_imm_op) begin
                     state_next = s_write;
                  end else if (instr.op == mov_reg_op) begin
                     state_next = s_read_b;
                  end
               end
               op_alu:   state_next = (alu_op == alu_mvn) ? s_read_b : s_read_a;
               op_load:  state_next = (instr.op == 2'b00) ? s_read_a : s_fetch;
               op_store: state_next = (instr.op == 2'b00) ? s_read_a : s_fetch;
               op_branch: begin
                  if (instr.op == 2'b00 && taken) begin
                     state_next = s_branch;
                  end
               end
               op_halt:  state_next = s_halt;
               default:  state_next = s_fetch;
            endcase
         end
         // ldr skips b, str reads rd into b here
         s_read_a:     state_next = (instr.opcode == op_load) ? s_alu : s_read_b;
         s_read_b:     state_next = s_alu;
         s_alu: begin
            if (instr.opcode == op_load || instr.opcode == op_store) begin
               state_next = s_addr;
            end else if (instr.opcode == op_alu && alu_op == alu_cmp) begin
               state_next = s_fetch;
            end else begin
               state_next = s_write;
            end
         end
         s_addr:       state_next = (instr.opcode == op_load) ? s_mem_wait : s_store_data;
         s_mem_wait:   state_next = s_write;
         s_store_data: state_next = s_store;
         // idle after reset too, until over is set
         s_halt:       state_next = over ? s_halt : s_fetch;
         default:      state_next = s_fetch;
      endcase
   end

   always_comb begin
      ctrl = '0;
      req = '0;
      load_ir = 1'b0;
      pc_incr = 1'b0;
      pc_branch = 1'b0;
      case (state)
         s_fetch: begin
            req.cmd = mem_read;
            req.use_pc = 1'b1;
         end
         s_load_ir: begin
            load_ir = 1'b1;
            pc_incr = 1'b1;
         end
         s_read_a: begin
            ctrl.load_a = 1'b1;
            ctrl.reg_sel = sel_rn;
         end
         s_read_b: begin
            ctrl.load_b = 1'b1;
            if (instr.opcode == op_store) begin
               ctrl.reg_sel = sel_rd;
            end else begin
               ctrl.reg_sel = sel_rm;
            end
         end
         s_alu: begin
            ctrl.load_c = 1'b1;
            ctrl.a_zero = (instr.opcode == op_move);
            ctrl.b_imm = (instr.opcode == op_load || instr.opcode == op_store);
            ctrl.load_flags = (instr.opcode == op_alu);
         end
         s_write: begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_sel = sel_rd;
            ctrl.wb_sel = wb_alu;
            if (instr.opcode == op_move && instr.op == mov_imm_op) begin
               ctrl.reg_sel = sel_rn;
               ctrl.wb_sel = wb_imm;
            end else if (instr.opcode == op_load) begin
               ctrl.wb_sel = wb_mem;
            end
         end
         s_addr:     req.load_addr = 1'b1;
         // read issued here, data is on read_data in s_write
         s_mem_wait: req.cmd = mem_read;
         s_store_data: begin
            // c takes 0 + rd
            ctrl.a_zero = 1'b1;
            ctrl.load_c = 1'b1;
         end
         s_store:    req.cmd = mem_write;
         s_branch:   pc_branch = 1'b1;
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= s_halt;
         over <= 1'b0;
      end else begin
         state <= state_next;
         if (state == s_decode && instr.opcode == op_halt) begin
            over <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   localparam int word_w = 16;
   localparam int addr_w = 9;
   localparam int reg_idx_w = 3;
   localparam int num_regs = 8;

   // op field values that tell the two MOV forms apart
   localparam logic [1:0] mov_reg_op = 2'b00;
   localparam logic [1:0] mov_imm_op = 2'b10;

   typedef logic [word_w-1:0] word_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      op_branch = 3'd1,
      op_load   = 3'd3,
      op_store  = 3'd4,
      op_alu    = 3'd5,
      op_move   = 3'd6,
      op_halt   = 3'd7
   } opcode_e;

   typedef enum logic [1:0] {alu_add, alu_cmp, alu_and, alu_mvn} alu_op_e;

   // branch condition, cond field of the branch class
   typedef enum logic [2:0] {cond_always, if_zero, if_not_zero} cond_e;

   typedef enum logic [1:0] {
      mem_none  = 2'b00,
      mem_write = 2'b01,
      mem_read  = 2'b10
   } mem_cmd_e;

   typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_e;
   typedef enum logic [1:0] {wb_alu, wb_imm, wb_mem} wb_sel_e;

   // decoded view of the instruction register
   typedef struct packed {
      opcode_e    opcode;
      logic [1:0] op;
      reg_idx_t   rn;
      reg_idx_t   rd;
      reg_idx_t   rm;
      cond_e      cond;
      word_t      imm8_sx;
      logic [4:0] imm5_zx;
   } instr_t;

   typedef struct packed {
      logic     load_a;
      logic     load_b;
      logic     load_c;
      logic     load_flags;
      logic     a_zero;
      logic     b_imm;
      logic     reg_write;
      reg_sel_e reg_sel;
      wb_sel_e  wb_sel;
   } ctrl_t;

   typedef struct packed {
      mem_cmd_e cmd;
      logic     use_pc;
      logic     load_addr;
   } mem_req_t;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  word_t    read_data,
   output mem_cmd_e mem_cmd,
   output addr_t    mem_addr,
   output word_t    write_data,
   output logic     n,
   output logic     v,
   output logic     z,
   output logic     over
);

   instr_t instr;
   addr_t pc;
   ctrl_t ctrl;
   mem_req_t req;
   logic load_ir;
   logic pc_incr;
   logic pc_branch;
   word_t c_out;

   fetch_unit u_fetch (
      .clk       (clk),
      .reset     (reset),
      .read_data (read_data),
      .load_ir   (load_ir),
      .pc_incr   (pc_incr),
      .pc_branch (pc_branch),
      .instr     (instr),
      .pc        (pc)
   );

   control_fsm u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .z         (z),
      .ctrl      (ctrl),
      .req       (req),
      .load_ir   (load_ir),
      .pc_incr   (pc_incr),
      .pc_branch (pc_branch),
      .over      (over)
   );

   datapath u_dp (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (ctrl),
      .instr     (instr),
      .read_data (read_data),
      .c_out     (c_out),
      .n         (n),
      .v         (v),
      .z         (z)
   );

   // store data is the c latch
   assign write_data = c_out;

   mem_port u_mem (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .pc       (pc),
      .c_out    (c_out),
      .mem_cmd  (mem_cmd),
      .mem_addr (mem_addr)
   );

endmodule

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  ctrl_t  ctrl,
   input  instr_t instr,
   input  word_t  read_data,
   output word_t  c_out,
   output logic   n,
   output logic   v,
   output logic   z
);

   word_t regs [num_regs];
   word_t a_q;
   word_t b_q;
   word_t a_in;
   word_t b_in;
   word_t alu_out;
   word_t wb_data;
   reg_idx_t sel_idx;
   alu_op_e alu_op;
   logic ovf;

   always_comb begin
      case (ctrl.reg_sel)
         sel_rn:  sel_idx = instr.rn;
         sel_rd:  sel_idx = instr.rd;
         default: sel_idx = instr.rm;
      endcase
   end

   always_comb begin
      case (ctrl.wb_sel)
         wb_imm:  wb_data = instr.imm8_sx;
         wb_mem:  wb_data = read_data;
         default: wb_data = c_out;
      endcase
   end

   // register file and operand latches
   always_ff @(posedge clk) begin
      if (ctrl.reg_write) begin
         regs[sel_idx] <= wb_data;
      end
      if (ctrl.load_a) begin
         a_q <= regs[sel_idx];
      end
      if (ctrl.load_b) begin
         b_q <= regs[sel_idx];
      end
      if (ctrl.load_c) begin
         c_out <= alu_out;
      end
   end

   // moves and address math always add
   assign alu_op = (instr.opcode == op_alu) ? alu_op_e'(instr.op) : alu_add;
   assign a_in = ctrl.a_zero ? '0 : a_q;
   assign b_in = ctrl.b_imm ? word_t'(instr.imm5_zx) : b_q;

   always_comb begin
      ovf = 1'b0;
      case (alu_op)
         alu_add: begin
            alu_out = a_in + b_in;
            ovf = (a_in[word_w-1] == b_in[word_w-1]) && (alu_out[word_w-1] != a_in[word_w-1]);
         end
         alu_cmp: begin
            alu_out = a_in - b_in;
            ovf = (a_in[word_w-1] != b_in[word_w-1]) && (alu_out[word_w-1] != a_in[word_w-1]);
         end
         alu_and: alu_out = a_in & b_in;
         default: alu_out = ~b_in;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         n <= 1'b0;
         v <= 1'b0;
         z <= 1'b0;
      end else if (ctrl.load_flags) begin
         n <= alu_out[word_w-1];
         v <= ovf;
         z <= (alu_out == '0);
      end
   end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  word_t  read_data,
   input  logic   load_ir,
   input  logic   pc_incr,
   input  logic   pc_branch,
   output instr_t instr,
   output addr_t  pc
);

   word_t ir;
   addr_t pc_next;

   // branch target is relative to the already incremented pc
   always_comb begin
      pc_next = pc;
      if (pc_branch) begin
         pc_next = pc + instr.imm8_sx[addr_w-1:0];
      end else if (pc_incr) begin
         pc_next = pc + addr_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         ir <= '0;
      end else begin
         pc <= pc_next;
         if (load_ir) begin
            ir <= read_data;
         end
      end
   end

   // field decode, rn and cond share bits 10:8
   always_comb begin
      instr.opcode  = opcode_e'(ir[15:13]);
      instr.op      = ir[12:11];
      instr.rn      = ir[10:8];
      instr.rd      = ir[7:5];
      instr.rm      = ir[2:0];
      instr.cond    = cond_e'(ir[10:8]);
      instr.imm8_sx = {{(word_w-8){ir[7]}}, ir[7:0]};
      instr.imm5_zx = ir[4:0];
   end

endmodule

`default_nettype wire

// File: design/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  mem_req_t req,
   input  addr_t    pc,
   input  word_t    c_out,
   output mem_cmd_e mem_cmd,
   output addr_t    mem_addr
);

   addr_t data_addr;

   // word address for ldr and str, low bits of the computed sum
   always_ff @(posedge clk) begin
      if (reset) begin
         data_addr <= '0;
      end else if (req.load_addr) begin
         data_addr <= c_out[addr_w-1:0];
      end
   end

   assign mem_addr = req.use_pc ? pc : data_addr;
   assign mem_cmd = req.cmd;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator and run, exit status is the simulation result
verilator --binary --timing --assert --top-module cpu_tb -f sources.f -o cpu_sim \
   && ./obj_dir/cpu_sim \
   || exit 1

// File: sources.f
design/cpu_pkg.sv
design/fetch_unit.sv
design/control_fsm.sv
design/datapath.sv
design/mem_port.sv
design/cpu_top.sv
tests/tb_clock.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

// File: tests/cpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_properties
   import cpu_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input logic     over,
   input mem_cmd_e mem_cmd
);

   // memory port idle in the cycle after reset
   idle_after_reset: assert property (@(posedge clk) reset |=> mem_cmd == mem_none)
      else $error("mem_cmd not idle in the cycle after reset");

   // over is sticky until reset
   over_sticky: assert property (@(posedge clk) (over && !reset) |=> over)
      else $error("over fell without reset");

   halted_port_idle: assert property (@(posedge clk) over |-> mem_cmd == mem_none)
      else $error("memory command issued while halted");

endmodule

bind cpu_top cpu_properties u_props (
   .clk     (clk),
   .reset   (reset),
   .over    (over),
   .mem_cmd (mem_cmd)
);

`default_nettype wire

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
   import cpu_pkg::*;
();

   // one program with its preset data word and expected results
   typedef struct packed {
      logic [9:0][15:0] prog;
      word_t            preset;
      word_t            expect_word;
      logic [2:0]       exp_nvz;
   } row_t;

   logic     clk;
   logic     reset;
   word_t    read_data;
   mem_cmd_e mem_cmd;
   addr_t    mem_addr;
   word_t    write_data;
   logic     n;
   logic     v;
   logic     z;
   logic     over;

   word_t    mem [512];
   mem_cmd_e cmd_s = mem_none;
   addr_t    addr_s;
   word_t    wdata_s;
   int       writes = 0;
   row_t     rows [$];

   tb_clock u_clk (
      .clk (clk)
   );

   cpu_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .read_data  (read_data),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .write_data (write_data),
      .n          (n),
      .v          (v),
      .z          (z),
      .over       (over)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   // memory model, pins sampled mid cycle and acted on after the edge
   always @(negedge clk) begin
      cmd_s = mem_cmd;
      addr_s = mem_addr;
      wdata_s = write_data;
   end

   always @(posedge clk) begin
      #1;
      if (cmd_s == mem_read) begin
         read_data = mem[addr_s];
      end else if (cmd_s == mem_write) begin
         assert (addr_s == 9'd201)
            else report_failure($sformatf("Fail at %0t: write to address %0d, expected 201",
                                          $time, addr_s));
         mem[addr_s] = wdata_s;
         writes++;
      end
   end

   // instruction encoding
   function automatic word_t mov_imm(input reg_idx_t rn, input logic [7:0] imm);
      return {op_move, mov_imm_op, rn, imm};
   endfunction

   function automatic word_t mov_reg(input reg_idx_t rd, input reg_idx_t rm);
      return {op_move, mov_reg_op, 3'd0, rd, 2'b00, rm};
   endfunction

   function automatic word_t alu_rr(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rn,
                                    input reg_idx_t rm);
      return {op_alu, op, rn, rd, 2'b00, rm};
   endfunction

   function automatic word_t load_word(input reg_idx_t rd, input reg_idx_t rn,
                                       input logic [4:0] off);
      return {op_load, 2'b00, rn, rd, off};
   endfunction

   function automatic word_t store_word(input reg_idx_t rd, input reg_idx_t rn,
                                        input logic [4:0] off);
      return {op_store, 2'b00, rn, rd, off};
   endfunction

   function automatic word_t branch_to(input cond_e c, input logic [7:0] off);
      return {op_branch, 2'b00, c, off};
   endfunction

   function automatic word_t halt_word();
      return {op_halt, 13'd0};
   endfunction

   function automatic word_t sext8(input logic [7:0] x);
      return {{8{x[7]}}, x};
   endfunction

   function automatic int as_int(input word_t w);
      return int'($signed(w));
   endfunction

   // n, v, z from the exact integer result of the operation
   function automatic logic [2:0] flags_of(input int full);
      logic [15:0] r;
      r = full[15:0];
      return {r[15], (full > 32767) || (full < -32768), r == 16'h0000};
   endfunction

   function automatic word_t fill_word(input addr_t a);
      return {a[6:0], a} ^ 16'hA5C3;
   endfunction

   function automatic row_t add_row(input logic [7:0] a, input logic [7:0] b);
      row_t r;
      r = '0;
      r.prog[0] = mov_imm(3'd7, 8'd100);
      r.prog[1] = alu_rr(alu_add, 3'd7, 3'd7, 3'd7);
      r.prog[2] = mov_imm(3'd0, a);
      r.prog[3] = mov_imm(3'd1, b);
      r.prog[4] = alu_rr(alu_add, 3'd2, 3'd0, 3'd1);
      r.prog[5] = store_word(3'd2, 3'd7, 5'd1);
      r.prog[6] = halt_word();
      r.expect_word = sext8(a) + sext8(b);
      r.exp_nvz = flags_of(as_int(sext8(a)) + as_int(sext8(b)));
      return r;
   endfunction

   function automatic row_t logic_row(input logic [7:0] a, input logic [7:0] b);
      row_t r;
      r = '0;
      r.prog[0] = mov_imm(3'd7, 8'd100);
      r.prog[1] = alu_rr(alu_add, 3'd7, 3'd7, 3'd7);
      r.prog[2] = mov_imm(3'd0, a);
      r.prog[3] = mov_imm(3'd1, b);
      r.prog[4] = alu_rr(alu_and, 3'd2, 3'd0, 3'd1);
      r.prog[5] = alu_rr(alu_mvn, 3'd3, 3'd0, 3'd2);
      r.prog[6] = mov_reg(3'd4, 3'd3);
      r.prog[7] = store_word(3'd4, 3'd7, 5'd1);
      r.prog[8] = halt_word();
      r.expect_word = ~(sext8(a) & sext8(b));
      r.exp_nvz = flags_of(as_int(r.expect_word));
      return r;
   endfunction

   // first operand comes from the preset word so it spans 16 bits
   function automatic row_t cmp_row(input word_t first, input logic [7:0] b);
      row_t r;
      r = '0;
      r.prog[0] = mov_imm(3'd7, 8'd100);
      r.prog[1] = alu_rr(alu_add, 3'd7, 3'd7, 3'd7);
      r.prog[2] = load_word(3'd0, 3'd7, 5'd0);
      r.prog[3] = mov_imm(3'd1, b);
      r.prog[4] = alu_rr(alu_cmp, 3'd3, 3'd0, 3'd1);
      r.prog[5] = halt_word();
      r.preset = first;
      r.expect_word = fill_word(9'd201);
      r.exp_nvz = flags_of(as_int(first) - as_int(sext8(b)));
      return r;
   endfunction

   function automatic row_t mem_row(input word_t preset);
      row_t r;
      r = '0;
      r.prog[0] = mov_imm(3'd1, 8'd98);
      r.prog[1] = alu_rr(alu_add, 3'd1, 3'd1, 3'd1);
      r.prog[2] = load_word(3'd2, 3'd1, 5'd4);
      r.prog[3] = mov_imm(3'd3, 8'd1);
      r.prog[4] = alu_rr(alu_add, 3'd2, 3'd2, 3'd3);
      r.prog[5] = store_word(3'd2, 3'd1, 5'd5);
      r.prog[6] = halt_word();
      r.preset = preset;
      r.expect_word = preset + 16'd1;
      r.exp_nvz = flags_of(as_int(preset) + 1);
      return r;
   endfunction

   function automatic row_t branch_row(input cond_e c, input logic [7:0] a, input logic [7:0] b);
      row_t r;
      logic taken;
      r = '0;
      r.prog[0] = mov_imm(3'd7, 8'd100);
      r.prog[1] = alu_rr(alu_add, 3'd7, 3'd7, 3'd7);
      r.prog[2] = mov_imm(3'd2, a);
      r.prog[3] = mov_imm(3'd1, b);
      r.prog[4] = alu_rr(alu_cmp, 3'd3, 3'd2, 3'd1);
      // a taken branch skips the overwrite
      r.prog[5] = branch_to(c, 8'd1);
      r.prog[6] = mov_imm(3'd2, 8'd77);
      r.prog[7] = store_word(3'd2, 3'd7, 5'd1);
      r.prog[8] = halt_word();
      case (c)
         if_zero:     taken = (a == b);
         if_not_zero: taken = (a != b);
         default:     taken = 1'b1;
      endcase
      r.expect_word = taken ? sext8(a) : sext8(8'd77);
      r.exp_nvz = flags_of(as_int(sext8(a)) - as_int(sext8(b)));
      return r;
   endfunction

   function automatic row_t loop_row();
      row_t r;
      r = '0;
      r.prog[0] = mov_imm(3'd7, 8'd100);
      r.prog[1] = alu_rr(alu_add, 3'd7, 3'd7, 3'd7);
      r.prog[2] = mov_imm(3'd2, 8'd0);
      r.prog[3] = mov_imm(3'd3, 8'd1);
      r.prog[4] = mov_imm(3'd4, 8'd3);
      r.prog[5] = alu_rr(alu_add, 3'd2, 3'd2, 3'd3);
      r.prog[6] = alu_rr(alu_cmp, 3'd5, 3'd2, 3'd4);
      // back to address 5 from the incremented pc 8
      r.prog[7] = branch_to(if_not_zero, 8'hFD);
      r.prog[8] = store_word(3'd2, 3'd7, 5'd1);
      r.prog[9] = halt_word();
      r.expect_word = 16'd3;
      r.exp_nvz = flags_of(3 - 3);
      return r;
   endfunction

   task automatic load_memory(input row_t r);
      for (int i = 0; i < 512; i++) begin
         mem[i] = fill_word(addr_t'(i));
      end
      for (int i = 0; i < 10; i++) begin
         mem[i] = r.prog[i];
      end
      mem[200] = r.preset;
   endtask

   task automatic wait_for_over();
      int cycles;
      cycles = 0;
      while (!over && cycles < 2000) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (over) else report_failure("timed out after 2000 cycles waiting for over");
   endtask

   // machine must stay halted and quiet
   task automatic watch_halt(input int idx);
      int writes_at_halt;
      writes_at_halt = writes;
      for (int c = 0; c < 20; c++) begin
         @(negedge clk);
         assert (over && mem_cmd == mem_none)
            else report_failure($sformatf("Fail at %0t: row %0d left the halt state",
                                          $time, idx));
      end
      assert (writes == writes_at_halt)
         else report_failure($sformatf("Fail at %0t: row %0d wrote memory after halt",
                                       $time, idx));
   endtask

   task automatic run_row(input int idx, input row_t r);
      @(posedge clk);
      #1;
      reset = 1'b1;
      load_memory(r);
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      assert (!over && {n, v, z} == 3'b000)
         else report_failure($sformatf("Fail at %0t: row %0d over or flags set after reset",
                                       $time, idx));
      wait_for_over();
      assert (mem[201] == r.expect_word)
         else report_failure($sformatf("Fail at %0t: row %0d mem[201] = %h, expected %h",
                                       $time, idx, mem[201], r.expect_word));
      assert ({n, v, z} == r.exp_nvz)
         else report_failure($sformatf("Fail at %0t: row %0d nvz = %b, expected %b",
                                       $time, idx, {n, v, z}, r.exp_nvz));
      watch_halt(idx);
   endtask

   initial begin
      reset = 1'b1;
      read_data = '0;
      rows.push_back(add_row(8'd20, 8'd22));
      rows.push_back(add_row(8'hF6, 8'd3));
      rows.push_back(add_row(8'h80, 8'h80));
      rows.push_back(logic_row(8'h3C, 8'h0F));
      rows.push_back(logic_row(8'hF0, 8'hFF));
      rows.push_back(cmp_row(16'd5, 8'd5));
      rows.push_back(cmp_row(16'd3, 8'd9));
      rows.push_back(cmp_row(16'h8000, 8'd1));
      rows.push_back(cmp_row(16'h7FFF, 8'hFF));
      rows.push_back(mem_row(16'h1234));
      rows.push_back(mem_row(16'hFFFF));
      rows.push_back(branch_row(if_zero, 8'd5, 8'd5));
      rows.push_back(branch_row(if_zero, 8'd5, 8'd6));
      rows.push_back(branch_row(if_not_zero, 8'd5, 8'd6));
      rows.push_back(branch_row(if_not_zero, 8'd9, 8'd9));
      rows.push_back(branch_row(cond_always, 8'd4, 8'd9));
      rows.push_back(loop_row());
      for (int k = 0; k < rows.size(); k++) begin
         run_row(k, rows[k]);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk
);

   // 8 ns period
   initial begin
      clk = 1'b0;
   end

   always #4 clk = ~clk;

endmodule

`default_nettype wire
